// File: list.f
source/mips_cfg_pkg.sv
source/mips_isa_pkg.sv
source/fetch_unit.sv
source/regfile.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/mips_core.sv
tests/mips_core_assert.sv
tests/mips_core_tb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - source/mips_cfg_pkg.sv
  - source/mips_isa_pkg.sv
  - source/fetch_unit.sv
  - source/regfile.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/result_stage.sv
  - source/mips_core.sv
  - target: test
    files:
      - tests/mips_core_assert.sv
      - tests/mips_core_tb.sv

// File: tests/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb;
    import mips_cfg_pkg::*;
    import mips_isa_pkg::*;

    localparam word_t RESET_PC = 32'hbfc00000;
    localparam int    NROWS    = 27;
    localparam int    TIMEOUT  = 20;

    typedef struct packed {
        word_t    word;
        logic     we;
        reg_idx_t wnum;
        word_t    wdata;
        word_t    pc;
    } row_t;

    logic       clk;
    logic       rst;
    word_t      inst_addr;
    word_t      inst_rdata;
    word_t      rom_idx;
    word_t      wb_pc;
    logic [3:0] wb_wen;
    reg_idx_t   wb_wnum;
    word_t      wb_wdata;

    row_t prog [NROWS];
    int   seed = 32'h01e93c34;
    int   errors = 0;
    int   tests = 0;
    int   cycles;

    mips_core #(
        .RESET_PC(RESET_PC)
    ) mips_core_inst (
        .clk                 (clk),
        .rst                 (rst),
        .inst_addr_o         (inst_addr),
        .inst_rdata_i        (inst_rdata),
        .debug_wb_pc_o       (wb_pc),
        .debug_wb_rf_wen_o   (wb_wen),
        .debug_wb_rf_wnum_o  (wb_wnum),
        .debug_wb_rf_wdata_o (wb_wdata)
    );

    // undecoded opcode tagged with the address beyond the program
    assign rom_idx    = (inst_addr - RESET_PC) >> 2;
    assign inst_rdata = (rom_idx < NROWS) ? prog[rom_idx].word
                                          : {6'h3f, inst_addr[31:6] ^ inst_addr[25:0]};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t i_type(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t r_type(funct_e fn, logic [4:0] rs, logic [4:0] rt,
                                     logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    task automatic build_program();
        logic [15:0] r [7];
        foreach (r[j]) r[j] = 16'($random(seed));
        foreach (prog[j]) prog[j] = '0;
        prog[0].word  = i_type(OP_ORI, 0, 1, r[0]);
        prog[1].word  = i_type(OP_LUI, 0, 2, r[1]);
        prog[2].word  = i_type(OP_ORI, 2, 2, r[2] | 16'h8000);   // bit 15 set so zero ext shows
        prog[3].word  = i_type(OP_ADDIU, 0, 3, r[3] | 16'h8000);  // negative imm
        prog[4].word  = i_type(OP_ANDI, 2, 4, r[4] | 16'h8000);
        prog[5].word  = i_type(OP_XORI, 3, 5, r[5] | 16'h8000);
        prog[6].word  = r_type(FN_ADDU, 1, 2, 6);
        prog[7].word  = r_type(FN_SUBU, 6, 3, 7);    // distance one
        prog[8].word  = r_type(FN_AND, 2, 6, 8);     // distance two
        prog[9].word  = r_type(FN_OR, 7, 8, 9);
        prog[10].word = r_type(FN_XOR, 9, 7, 10);
        prog[11].word = r_type(FN_NOR, 10, 9, 11);
        prog[12].word = r_type(FN_SLT, 3, 1, 12);
        prog[13].word = r_type(FN_SLTU, 3, 1, 13);
        prog[14].word = r_type(FN_ADDU, 1, 2, 0);    // dest r0
        prog[15].word = 32'hfc00_0000;               // unknown opcode
        prog[16].word = r_type(FN_OR, 0, 0, 14);
        prog[17].word = i_type(OP_BEQ, 1, 1, 16'd2); // taken
        prog[18].word = i_type(OP_ADDIU, 1, 15, 16'd1);
        prog[19].word = i_type(OP_ADDIU, 0, 16, 16'd7);
        prog[20].word = i_type(OP_BNE, 1, 1, 16'd2); // not taken
        prog[21].word = i_type(OP_ORI, 0, 17, r[6] | 16'h0001);
        prog[22].word = r_type(FN_SLTU, 1, 3, 18);
        prog[23].word = i_type(OP_BNE, 17, 0, 16'd2);
        prog[24].word = r_type(FN_XOR, 17, 15, 19);
        prog[25].word = i_type(OP_ADDIU, 0, 20, 16'd5);
        prog[26].word = r_type(FN_SUBU, 19, 1, 21);
    endtask

    // walks the program in execution order including delay slots
    task automatic run_model();
        word_t shadow [NREGS];
        word_t w;
        word_t a;
        word_t b;
        word_t sext;
        word_t res;
        logic  taken;
        int    k;
        int    next;
        int    pending;
        foreach (shadow[j]) shadow[j] = '0;
        k = 0;
        pending = -1;
        while (k < NROWS) begin
            w     = prog[k].word;
            a     = shadow[w[25:21]];
            b     = shadow[w[20:16]];
            sext  = {{16{w[15]}}, w[15:0]};
            res   = '0;
            taken = 1'b0;
            prog[k].pc   = RESET_PC + 4 * k;
            prog[k].we   = 1'b1;
            prog[k].wnum = w[20:16];
            case (w[31:26])
                OP_SPECIAL: begin
                    prog[k].wnum = w[15:11];
                    case (w[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_NOR:  res = ~(a | b);
                        FN_SLT:  res = word_t'($signed(a) < $signed(b));
                        FN_SLTU: res = word_t'(a < b);
                        default: prog[k].we = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + sext;
                OP_ANDI:  res = a & {16'h0, w[15:0]};
                OP_ORI:   res = a | {16'h0, w[15:0]};
                OP_XORI:  res = a ^ {16'h0, w[15:0]};
                OP_LUI:   res = {w[15:0], 16'h0};
                OP_BEQ, OP_BNE: begin
                    prog[k].we = 1'b0;
                    taken = (a == b) ^ (w[31:26] == OP_BNE);
                end
                default:  prog[k].we = 1'b0;
            endcase
            if (prog[k].wnum == 0) prog[k].we = 1'b0;
            if (prog[k].we) shadow[prog[k].wnum] = res;
            prog[k].wdata = res;
            next = (pending >= 0) ? pending : k + 1;
            pending = taken ? k + 1 + int'($signed(w[15:0])) : -1;
            k = next;
        end
    endtask

    task automatic check_val(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            $display("[ERROR] %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // n comes back above TIMEOUT when nothing was written
    task automatic wait_write(output int n);
        n = 0;
        while (wb_wen == 4'h0) begin
            if (n == TIMEOUT) begin
                $display("timed out waiting for a register write");
                errors++;
                n++;
                return;
            end
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    initial begin
        rst = 1'b1;
        build_program();
        run_model();
        repeat (10) begin
            @(posedge clk);
            #1;
            check_val("debug_wb_rf_wen_o", '0, word_t'(wb_wen));
        end
        rst = 1'b0;
        check_val("inst_addr_o", RESET_PC, inst_addr);
        wait_write(cycles);
        assert (cycles == 3) else begin
            $display("first writeback came %0d edges after reset instead of 3", cycles);
            errors++;
        end
        tests++;
        $display("test %0d reset finished", tests);
        foreach (prog[i]) begin
            if (prog[i].we) begin
                wait_write(cycles);
                if (cycles > TIMEOUT) break;
                check_val("debug_wb_pc_o", prog[i].pc, wb_pc);
                check_val("debug_wb_rf_wnum_o", word_t'(prog[i].wnum), word_t'(wb_wnum));
                check_val("debug_wb_rf_wdata_o", prog[i].wdata, wb_wdata);
                tests++;
                $display("test %0d writeback at pc %h finished", tests, prog[i].pc);
                @(posedge clk);
                #1;
            end
        end
        repeat (8) begin  // nothing may write after the last row
            @(posedge clk);
            #1;
            check_val("debug_wb_rf_wen_o", '0, word_t'(wb_wen));
        end
        tests++;
        $display("test %0d drain finished", tests);
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tests/mips_core_assert.sv
`timescale 1ns/1ps

module mips_core_assert (
    input logic                   clk,
    input logic                   rst,
    input mips_cfg_pkg::word_t    inst_addr_i,
    input logic [3:0]             wen_i,
    input mips_cfg_pkg::reg_idx_t wnum_i
);

    // result register is clear one edge into reset
    no_wen_in_reset: assert property (@(posedge clk) rst |=> wen_i == 4'h0)
        else $error("debug write enable set during reset");

    wnum_nonzero: assert property (@(posedge clk) disable iff (rst)
        wen_i != 4'h0 |-> wnum_i != '0)
        else $error("debug write to register 0");

    addr_aligned: assert property (@(posedge clk) disable iff (rst) inst_addr_i[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule

bind mips_core mips_core_assert mips_core_assert_inst (
    .clk         (clk),
    .rst         (rst),
    .inst_addr_i (inst_addr_o),
    .wen_i       (debug_wb_rf_wen_o),
    .wnum_i      (debug_wb_rf_wnum_o)
);

// File: source/mips_core.sv
`timescale 1ns/1ps

module mips_core #(
    parameter mips_cfg_pkg::word_t RESET_PC = mips_cfg_pkg::DEFAULT_RESET_PC
) (
    input  logic                   clk,
    input  logic                   rst,
    output mips_cfg_pkg::word_t    inst_addr_o,
    input  mips_cfg_pkg::word_t    inst_rdata_i,
    output mips_cfg_pkg::word_t    debug_wb_pc_o,
    output logic [3:0]             debug_wb_rf_wen_o,
    output mips_cfg_pkg::reg_idx_t debug_wb_rf_wnum_o,
    output mips_cfg_pkg::word_t    debug_wb_rf_wdata_o
);
    import mips_cfg_pkg::*;
    import mips_isa_pkg::*;

    fetch_rec_t fetch_rec;
    ex_rec_t    ex_rec;
    res_rec_t   ex_bypass;
    res_rec_t   res_rec;
    res_rec_t   res_bypass;

    logic       redirect;
    word_t      target;

    reg_idx_t   rf_raddr_a;
    reg_idx_t   rf_raddr_b;
    word_t      rf_rdata_a;
    word_t      rf_rdata_b;
    logic       rf_we;
    reg_idx_t   rf_waddr;
    word_t      rf_wdata;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .redirect_i   (redirect),
        .target_i     (target),
        .inst_rdata_i (inst_rdata_i),
        .inst_addr_o  (inst_addr_o),
        .fetch_o      (fetch_rec)
    );

    decode_stage decode_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .fetch_i      (fetch_rec),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_rdata_a_i (rf_rdata_a),
        .rf_rdata_b_i (rf_rdata_b),
        .ex_bypass_i  (ex_bypass),
        .res_bypass_i (res_bypass),
        .redirect_o   (redirect),
        .target_o     (target),
        .ex_o         (ex_rec)
    );

    regfile regfile_inst (
        .clk       (clk),
        .rst       (rst),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    execute_stage execute_stage_inst (
        .clk      (clk),
        .rst      (rst),
        .ex_i     (ex_rec),
        .bypass_o (ex_bypass),
        .res_o    (res_rec)
    );

    result_stage result_stage_inst (
        .res_i               (res_rec),
        .rf_we_o             (rf_we),
        .rf_waddr_o          (rf_waddr),
        .rf_wdata_o          (rf_wdata),
        .bypass_o            (res_bypass),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

endmodule

// File: source/result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  mips_isa_pkg::res_rec_t res_i,
    output logic                   rf_we_o,
    output mips_cfg_pkg::reg_idx_t rf_waddr_o,
    output mips_cfg_pkg::word_t    rf_wdata_o,
    output mips_isa_pkg::res_rec_t bypass_o,
    output mips_cfg_pkg::word_t    debug_wb_pc_o,
    output logic [3:0]             debug_wb_rf_wen_o,
    output mips_cfg_pkg::reg_idx_t debug_wb_rf_wnum_o,
    output mips_cfg_pkg::word_t    debug_wb_rf_wdata_o
);
    import mips_cfg_pkg::*;

    logic commit;

    // r0 writes were already dropped in decode
    assign commit = res_i.valid && res_i.we;

    assign rf_we_o    = commit;
    assign rf_waddr_o = res_i.rd;
    assign rf_wdata_o = res_i.result;

    // second bypass, covers distance two
    assign bypass_o = res_i;

    // debug port mirrors the regfile write
    assign debug_wb_pc_o       = res_i.pc;
    assign debug_wb_rf_wen_o   = {4{commit}};
    assign debug_wb_rf_wnum_o  = rf_waddr_o;
    assign debug_wb_rf_wdata_o = rf_wdata_o;

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  mips_isa_pkg::ex_rec_t  ex_i,
    output mips_isa_pkg::res_rec_t bypass_o,
    output mips_isa_pkg::res_rec_t res_o
);
    import mips_cfg_pkg::*;
    import mips_isa_pkg::*;

    word_t alu_res;
    logic  lt_signed;
    logic  lt_unsigned;

    assign lt_signed   = $signed(ex_i.op_a) < $signed(ex_i.op_b);
    assign lt_unsigned = ex_i.op_a < ex_i.op_b;

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:  alu_res = ex_i.op_a + ex_i.op_b;   // wraps, no overflow trap
            ALU_SUB:  alu_res = ex_i.op_a - ex_i.op_b;
            ALU_AND:  alu_res = ex_i.op_a & ex_i.op_b;
            ALU_OR:   alu_res = ex_i.op_a | ex_i.op_b;
            ALU_XOR:  alu_res = ex_i.op_a ^ ex_i.op_b;
            ALU_NOR:  alu_res = ~(ex_i.op_a | ex_i.op_b);
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_LUI:  alu_res = {ex_i.op_b[XLEN/2-1:0], {(XLEN/2){1'b0}}};
            default:  alu_res = '0;
        endcase
    end

    // same-cycle result, forwarded to decode
    always_comb begin
        bypass_o.valid  = ex_i.valid;
        bypass_o.pc     = ex_i.pc;
        bypass_o.we     = ex_i.we;
        bypass_o.rd     = ex_i.rd;
        bypass_o.result = alu_res;
    end

    always_ff @(posedge clk) begin
        res_o <= bypass_o;
        if (rst) begin
            res_o.valid <= 1'b0;
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  mips_isa_pkg::fetch_rec_t fetch_i,
    output mips_cfg_pkg::reg_idx_t   rf_raddr_a_o,
    output mips_cfg_pkg::reg_idx_t   rf_raddr_b_o,
    input  mips_cfg_pkg::word_t      rf_rdata_a_i,
    input  mips_cfg_pkg::word_t      rf_rdata_b_i,
    input  mips_isa_pkg::res_rec_t   ex_bypass_i,
    input  mips_isa_pkg::res_rec_t   res_bypass_i,
    output logic                     redirect_o,
    output mips_cfg_pkg::word_t      target_o,
    output mips_isa_pkg::ex_rec_t    ex_o
);
    import mips_cfg_pkg::*;
    import mips_isa_pkg::*;

    opcode_e     opcode;
    funct_e      funct;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    logic [15:0] imm;
    word_t       imm_sext;
    word_t       imm_ext;
    word_t       fwd_a;
    word_t       fwd_b;
    alu_op_e     alu_op;
    logic        wr_en;
    reg_idx_t    dst;
    ex_rec_t     ex_next;

    // nearest producer wins
    function automatic word_t forward(reg_idx_t idx, word_t rf_val,
                                      res_rec_t near, res_rec_t far);
        if (near.valid && near.we && near.rd == idx) begin
            return near.result;
        end
        if (far.valid && far.we && far.rd == idx) begin
            return far.result;
        end
        return rf_val;
    endfunction

    assign opcode = opcode_e'(fetch_i.inst[31:26]);
    assign funct  = funct_e'(fetch_i.inst[5:0]);
    assign rs     = fetch_i.inst[25:21];
    assign rt     = fetch_i.inst[20:16];
    assign rd     = fetch_i.inst[15:11];
    assign imm    = fetch_i.inst[15:0];

    assign imm_sext = {{(XLEN-16){imm[15]}}, imm};
    assign imm_ext  = (opcode == OP_ADDIU) ? imm_sext : {{(XLEN-16){1'b0}}, imm};

    assign rf_raddr_a_o = rs;
    assign rf_raddr_b_o = rt;
    assign fwd_a = forward(rs, rf_rdata_a_i, ex_bypass_i, res_bypass_i);
    assign fwd_b = forward(rt, rf_rdata_b_i, ex_bypass_i, res_bypass_i);

    always_comb begin
        alu_op = ALU_ADD;
        wr_en  = 1'b1;
        dst    = rt;   // immediates write rt
        case (opcode)
            OP_SPECIAL: begin
                dst = rd;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    default: wr_en = 1'b0;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_ANDI:  alu_op = ALU_AND;
            OP_ORI:   alu_op = ALU_OR;
            OP_XORI:  alu_op = ALU_XOR;
            OP_LUI:   alu_op = ALU_LUI;
            default:  wr_en = 1'b0;  // branches and unknown opcodes
        endcase
        if (dst == '0) begin
            wr_en = 1'b0;
        end
    end

    assign redirect_o = fetch_i.valid &&
                        ((opcode == OP_BEQ && fwd_a == fwd_b) ||
                         (opcode == OP_BNE && fwd_a != fwd_b));
    assign target_o   = fetch_i.pc + word_t'(4) + {imm_sext[XLEN-3:0], 2'b00};

    always_comb begin
        ex_next.valid  = fetch_i.valid;
        ex_next.pc     = fetch_i.pc;
        ex_next.alu_op = alu_op;
        ex_next.op_a   = fwd_a;
        ex_next.op_b   = (opcode == OP_SPECIAL) ? fwd_b : imm_ext;
        ex_next.we     = wr_en;
        ex_next.rd     = dst;
    end

    always_ff @(posedge clk) begin
        ex_o <= ex_next;
        if (rst) begin
            ex_o.valid <= 1'b0;
        end
    end

endmodule

// File: source/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  mips_cfg_pkg::reg_idx_t raddr_a_i,
    input  mips_cfg_pkg::reg_idx_t raddr_b_i,
    output mips_cfg_pkg::word_t    rdata_a_o,
    output mips_cfg_pkg::word_t    rdata_b_o,
    input  logic                   we_i,
    input  mips_cfg_pkg::reg_idx_t waddr_i,
    input  mips_cfg_pkg::word_t    wdata_i
);
    import mips_cfg_pkg::*;

    word_t regs [1:NREGS-1];  // no storage behind r0

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter mips_cfg_pkg::word_t RESET_PC = mips_cfg_pkg::DEFAULT_RESET_PC
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     redirect_i,
    input  mips_cfg_pkg::word_t      target_i,
    input  mips_cfg_pkg::word_t      inst_rdata_i,
    output mips_cfg_pkg::word_t      inst_addr_o,
    output mips_isa_pkg::fetch_rec_t fetch_o
);
    import mips_cfg_pkg::*;

    word_t pc;
    word_t pc_next;

    // redirect arrives while the delay slot is on the bus
    assign pc_next     = redirect_i ? target_i : pc + word_t'(4);
    assign inst_addr_o = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        fetch_o.pc   <= pc;
        fetch_o.inst <= inst_rdata_i;  // rom answers in the same cycle
        if (rst) begin
            fetch_o.valid <= 1'b0;
        end else begin
            fetch_o.valid <= 1'b1;
        end
    end

endmodule

// File: source/mips_isa_pkg.sv
package mips_isa_pkg;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // SPECIAL function field, inst[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic                valid;
        mips_cfg_pkg::word_t pc;
        mips_cfg_pkg::word_t inst;
    } fetch_rec_t;

    typedef struct packed {
        logic                   valid;
        mips_cfg_pkg::word_t    pc;
        alu_op_e                alu_op;
        mips_cfg_pkg::word_t    op_a;
        mips_cfg_pkg::word_t    op_b;   // register or extended immediate
        logic                   we;
        mips_cfg_pkg::reg_idx_t rd;
    } ex_rec_t;

    typedef struct packed {
        logic                   valid;
        mips_cfg_pkg::word_t    pc;
        logic                   we;
        mips_cfg_pkg::reg_idx_t rd;
        mips_cfg_pkg::word_t    result;
    } res_rec_t;

endpackage

// File: source/mips_cfg_pkg.sv
package mips_cfg_pkg;

    // machine dimensions
    localparam int unsigned XLEN  = 32;
    localparam int unsigned NREGS = 32;

    typedef logic [XLEN-1:0]          word_t;
    typedef logic [$clog2(NREGS)-1:0] reg_idx_t;

    // boot rom entry in kseg1
    localparam word_t DEFAULT_RESET_PC = 32'hbfc00000;

endpackage
